// ==== arb_pkg.sv ====
package arb_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------

	parameter int data_w    = 32;
	parameter int be_w      = 4;
	parameter int num_ports = 4;

	typedef logic [data_w-1:0]            addr_t;
	typedef logic [data_w-1:0]            data_t;
	typedef logic [be_w-1:0]              be_t;
	typedef logic [$clog2(num_ports)-1:0] port_idx_t;

	// ------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------

	// bytes per access on a port
	typedef enum logic [2:0] {
		size_byte = 3'd1,
		size_half = 3'd2,
		size_word = 3'd4
	} port_size_e;

	// gray order, one bit flips per step
	typedef enum logic [1:0] {
		port_idle    = 2'b00,	// no request
		port_wait    = 2'b01,	// pending at sequencer
		port_hold    = 2'b11,	// acked, req still high
		port_release = 2'b10	// back to idle
	} port_state_e;

	typedef enum logic [1:0] {
		seq_idle    = 2'b00,	// free to grant
		seq_busy    = 2'b01,	// dev_req high
		seq_done    = 2'b11,	// device word registered
		seq_recover = 2'b10	// gap cycle
	} seq_state_e;

endpackage

// ==== arb_port_if.sv ====
interface arb_port_if;
	import arb_pkg::*;

	logic  pending;	// waiting for a grant
	addr_t addr;
	data_t wdata;
	be_t   be;
	logic  wr;
	logic  done;	// transfer of this port finished
	data_t rdata;	// registered device word

	modport ctrl (
		output pending,
		output addr,
		output wdata,
		output be,
		output wr,
		input  done,
		input  rdata
	);

	modport seq (
		input  pending,
		input  addr,
		input  wdata,
		input  be,
		input  wr,
		output done,
		output rdata
	);

endinterface

// ==== arb_port_ctrl.sv ====
module arb_port_ctrl #(
	parameter arb_pkg::port_size_e port_size = arb_pkg::size_word
) (
	input  logic           dev_clk,
	input  logic           dev_rst_n,
	input  logic           req,
	input  arb_pkg::addr_t addr,
	input  arb_pkg::data_t wdata,
	input  arb_pkg::be_t   be,
	input  logic           wr,
	output logic           ack,
	output arb_pkg::data_t rdata,
	arb_port_if.ctrl       bus
);
	import arb_pkg::*;

	port_state_e state;
	port_state_e state_nxt;
	data_t       lane_data;
	logic        finish;

	assign bus.pending = (state == port_wait);
	assign bus.addr    = addr;	// master holds these until ack
	assign bus.wdata   = wdata;
	assign bus.be      = be;
	assign bus.wr      = wr;

	assign finish = (state == port_wait) && bus.done;

	// ------------------------------------------------------------
	// request state machine
	// ------------------------------------------------------------

	always_comb
	begin
		state_nxt = state;
		case (state)
			port_idle:
				if (req)
					state_nxt = port_wait;
			port_wait:
				if (bus.done)
					state_nxt = port_hold;
			port_hold:
				if (!req)
					state_nxt = port_release;	// needs req low first
			default:
				state_nxt = port_idle;
		endcase
	end

	// ------------------------------------------------------------
	// read lane select, big-endian lanes
	// ------------------------------------------------------------

	always_comb
	begin
		case (port_size)
			size_byte:
				case (addr[1:0])
					2'b00: lane_data = {4{bus.rdata[31:24]}};
					2'b01: lane_data = {4{bus.rdata[23:16]}};
					2'b10: lane_data = {4{bus.rdata[15:8]}};
					default: lane_data = {4{bus.rdata[7:0]}};
				endcase
			size_half:
				lane_data = addr[1] ? {2{bus.rdata[15:0]}} : {2{bus.rdata[31:16]}};
			default:
				lane_data = bus.rdata;	// full word
		endcase
	end

	always_ff @(posedge dev_clk)
	begin
		if (!dev_rst_n)
		begin
			state <= port_idle;
			ack   <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			state <= state_nxt;
			ack   <= finish;	// one cycle pulse
			if (finish && !wr)
				rdata <= lane_data;	// kept until next read
		end
	end

endmodule

// ==== arb_dev_seq.sv ====
module arb_dev_seq (
	input  logic           dev_clk,
	input  logic           dev_rst_n,
	input  logic           lock,
	input  arb_pkg::data_t dev_rdata,
	input  logic           dev_ack,
	output arb_pkg::addr_t dev_addr,
	output arb_pkg::data_t dev_wdata,
	output arb_pkg::be_t   dev_be,
	output logic           dev_wr,
	output logic           dev_req,
	arb_port_if.seq        bus [arb_pkg::num_ports]
);
	import arb_pkg::*;

	seq_state_e           state;
	port_idx_t            master;
	port_idx_t            winner;
	logic [num_ports-1:0] pending;
	logic [num_ports-1:0] eligible;
	logic [num_ports-1:0] wr_v;
	addr_t                addr_v [num_ports];
	data_t                wdata_v [num_ports];
	be_t                  be_v [num_ports];
	data_t                rdata_r;
	logic                 grant;

	// ------------------------------------------------------------
	// per port fan in and fan out
	// ------------------------------------------------------------

	for (genvar i = 0; i < num_ports; i++)
	begin : g_port
		assign pending[i] = bus[i].pending;
		assign addr_v[i]  = bus[i].addr;
		assign wdata_v[i] = bus[i].wdata;
		assign be_v[i]    = bus[i].be;
		assign wr_v[i]    = bus[i].wr;

		assign bus[i].done  = (state == seq_done) && (master == port_idx_t'(i));
		assign bus[i].rdata = rdata_r;
	end

	// lock leaves only port 0 in the running
	assign eligible = lock ? {{(num_ports-1){1'b0}}, pending[0]} : pending;
	assign grant    = |eligible;

	always_comb
	begin
		winner = '0;
		for (int i = num_ports - 1; i >= 0; i--)
		begin
			if (eligible[i])
				winner = port_idx_t'(i);	// lowest index wins
		end
	end

	// ------------------------------------------------------------
	// device cycle
	// ------------------------------------------------------------

	always_ff @(posedge dev_clk)
	begin
		if (!dev_rst_n)
		begin
			state  <= seq_idle;
			master <= '0;
			dev_wr <= 1'b0;
		end
		else
		begin
			case (state)
				seq_idle:
					if (grant)
					begin
						state  <= seq_busy;
						master <= winner;
						dev_wr <= wr_v[winner];
					end
				seq_busy:
					if (dev_ack)
						state <= seq_done;	// stall until device answers
				seq_done:
					state <= seq_recover;
				default:
					state <= seq_idle;
			endcase
		end
	end

	always_ff @(posedge dev_clk)
	begin
		if ((state == seq_idle) && grant)
		begin
			dev_addr  <= addr_v[winner];
			dev_wdata <= wdata_v[winner];
			dev_be    <= be_v[winner];
		end
		if ((state == seq_busy) && dev_ack)
			rdata_r <= dev_rdata;
	end

	assign dev_req = (state == seq_busy);

endmodule

// ==== gen_arb32.sv ====
module gen_arb32 #(
	parameter arb_pkg::port_size_e p0_size = arb_pkg::size_half,
	parameter arb_pkg::port_size_e p1_size = arb_pkg::size_half,
	parameter arb_pkg::port_size_e p2_size = arb_pkg::size_half,
	parameter arb_pkg::port_size_e p3_size = arb_pkg::size_half
) (
	output arb_pkg::addr_t dev_addr,
	output arb_pkg::data_t dev_wdata,
	output arb_pkg::be_t   dev_be,
	input  arb_pkg::data_t dev_rdata,
	output logic           dev_wr,
	output logic           dev_req,
	input  logic           dev_ack,

	input  arb_pkg::addr_t p0_addr,
	input  arb_pkg::data_t p0_wdata,
	input  arb_pkg::be_t   p0_be,
	output arb_pkg::data_t p0_rdata,
	input  logic           p0_wr,
	input  logic           p0_req,
	output logic           p0_ack,
	input  logic           p0_busreq,
	output logic           p0_busack,

	input  arb_pkg::addr_t p1_addr,
	input  arb_pkg::data_t p1_wdata,
	input  arb_pkg::be_t   p1_be,
	output arb_pkg::data_t p1_rdata,
	input  logic           p1_wr,
	input  logic           p1_req,
	output logic           p1_ack,

	input  arb_pkg::addr_t p2_addr,
	input  arb_pkg::data_t p2_wdata,
	input  arb_pkg::be_t   p2_be,
	output arb_pkg::data_t p2_rdata,
	input  logic           p2_wr,
	input  logic           p2_req,
	output logic           p2_ack,

	input  arb_pkg::addr_t p3_addr,
	input  arb_pkg::data_t p3_wdata,
	input  arb_pkg::be_t   p3_be,
	output arb_pkg::data_t p3_rdata,
	input  logic           p3_wr,
	input  logic           p3_req,
	output logic           p3_ack,

	input  logic           dev_clk,
	input  logic           dev_rst_n
);
	import arb_pkg::*;

	arb_port_if port_bus [num_ports] ();

	assign p0_busack = p0_busreq;	// lock granted at once

	// ------------------------------------------------------------
	// port controllers, port 0 highest priority
	// ------------------------------------------------------------

	arb_port_ctrl #(.port_size(p0_size)) u_port0 (
		.dev_clk(dev_clk), .dev_rst_n(dev_rst_n),
		.req(p0_req), .addr(p0_addr), .wdata(p0_wdata), .be(p0_be), .wr(p0_wr),
		.ack(p0_ack), .rdata(p0_rdata), .bus(port_bus[0])
	);

	arb_port_ctrl #(.port_size(p1_size)) u_port1 (
		.dev_clk(dev_clk), .dev_rst_n(dev_rst_n),
		.req(p1_req), .addr(p1_addr), .wdata(p1_wdata), .be(p1_be), .wr(p1_wr),
		.ack(p1_ack), .rdata(p1_rdata), .bus(port_bus[1])
	);

	arb_port_ctrl #(.port_size(p2_size)) u_port2 (
		.dev_clk(dev_clk), .dev_rst_n(dev_rst_n),
		.req(p2_req), .addr(p2_addr), .wdata(p2_wdata), .be(p2_be), .wr(p2_wr),
		.ack(p2_ack), .rdata(p2_rdata), .bus(port_bus[2])
	);

	arb_port_ctrl #(.port_size(p3_size)) u_port3 (
		.dev_clk(dev_clk), .dev_rst_n(dev_rst_n),
		.req(p3_req), .addr(p3_addr), .wdata(p3_wdata), .be(p3_be), .wr(p3_wr),
		.ack(p3_ack), .rdata(p3_rdata), .bus(port_bus[3])
	);

	arb_dev_seq u_seq (
		.dev_clk(dev_clk),
		.dev_rst_n(dev_rst_n),
		.lock(p0_busreq),	// hold off ports 1 to 3
		.dev_rdata(dev_rdata),
		.dev_ack(dev_ack),
		.dev_addr(dev_addr),
		.dev_wdata(dev_wdata),
		.dev_be(dev_be),
		.dev_wr(dev_wr),
		.dev_req(dev_req),
		.bus(port_bus)
	);

endmodule

// ==== gen_arb32_tb.sv ====
module gen_arb32_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import arb_pkg::*;

	localparam int max_cycles = 2000;	// roughly 4x the full test run

	logic             dev_clk;
	logic             dev_rst_n;
	addr_t            dev_addr;
	data_t            dev_wdata;
	be_t              dev_be;
	data_t            dev_rdata;
	logic             dev_wr;
	logic             dev_req;
	logic             dev_ack;
	logic             p0_busreq;
	logic             p0_busack;
	logic [3:0][31:0] p_addr;
	logic [3:0][31:0] p_wdata;
	logic [3:0][31:0] p_rdata;
	logic [3:0][3:0]  p_be;
	logic [3:0]       p_wr;
	logic [3:0]       p_req;
	logic [3:0]       p_ack;
	logic [31:0]      dev_mem [64];
	logic [31:0]      ref_mem [64];
	logic [31:0]      addr_log [$];	// dev_addr of every device request
	int               cycle_cnt = 0;

	gen_arb32 #(
		.p0_size(size_word),
		.p1_size(size_half),
		.p2_size(size_byte),
		.p3_size(size_word)
	) dut (
		.dev_addr(dev_addr), .dev_wdata(dev_wdata), .dev_be(dev_be), .dev_rdata(dev_rdata),
		.dev_wr(dev_wr), .dev_req(dev_req), .dev_ack(dev_ack),
		.p0_addr(p_addr[0]), .p0_wdata(p_wdata[0]), .p0_be(p_be[0]), .p0_rdata(p_rdata[0]),
		.p0_wr(p_wr[0]), .p0_req(p_req[0]), .p0_ack(p_ack[0]),
		.p0_busreq(p0_busreq), .p0_busack(p0_busack),
		.p1_addr(p_addr[1]), .p1_wdata(p_wdata[1]), .p1_be(p_be[1]), .p1_rdata(p_rdata[1]),
		.p1_wr(p_wr[1]), .p1_req(p_req[1]), .p1_ack(p_ack[1]),
		.p2_addr(p_addr[2]), .p2_wdata(p_wdata[2]), .p2_be(p_be[2]), .p2_rdata(p_rdata[2]),
		.p2_wr(p_wr[2]), .p2_req(p_req[2]), .p2_ack(p_ack[2]),
		.p3_addr(p_addr[3]), .p3_wdata(p_wdata[3]), .p3_be(p_be[3]), .p3_rdata(p_rdata[3]),
		.p3_wr(p_wr[3]), .p3_req(p_req[3]), .p3_ack(p_ack[3]),
		.dev_clk(dev_clk), .dev_rst_n(dev_rst_n)
	);

	initial
	begin
		dev_clk = 1'b0;
		forever
			#10 dev_clk = ~dev_clk;
	end

	always @(posedge dev_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles)
		begin
			$display("timeout: tests still running after %0d cycles", max_cycles);
			$display("TB FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] fill_word(input logic [5:0] idx);
		logic [31:0] a;
		a = {26'd0, idx};
		return (a * 32'h0407_0b0d) ^ (a << 26) ^ 32'h5a3c_9611;
	endfunction

	// ------------------------------------------------------------
	// device model of 64 words with random wait states
	// ------------------------------------------------------------

	initial
	begin
		int unsigned extra;
		logic [5:0]  idx;
		logic [6:0]  i;
		logic [31:0] mask;
		void'($urandom(59));
		dev_ack   = 1'b0;
		dev_rdata = '0;
		for (i = 7'd0; i < 7'd64; i++)
			dev_mem[i[5:0]] = fill_word(i[5:0]);
		forever
		begin
			@(posedge dev_clk);
			if (dev_rst_n && dev_req)
			begin
				addr_log.push_back(dev_addr);
				extra = $urandom_range(3);	// 0 to 3 extra cycles
				repeat (extra)
					@(posedge dev_clk);
				#2;
				idx  = dev_addr[7:2];
				mask = {{8{dev_be[3]}}, {8{dev_be[2]}}, {8{dev_be[1]}}, {8{dev_be[0]}}};
				if (dev_wr)
					dev_mem[idx] = (dev_mem[idx] & ~mask) | (dev_wdata & mask);
				dev_rdata = dev_mem[idx];
				dev_ack   = 1'b1;
				@(posedge dev_clk);
				#2;
				dev_ack   = 1'b0;
			end
		end
	end

	// expected port data with lane 0 as the msb byte
	function automatic logic [31:0] expect_read(input port_idx_t port, input logic [31:0] addr);
		logic [31:0] w;
		logic [7:0]  b;
		logic [15:0] h;
		w = ref_mem[addr[7:2]];
		b = 8'(w >> (8 * (3 - 32'(addr[1:0]))));
		h = 16'(addr[1] ? w : w >> 16);
		if (port == 2'd2)
			return {4{b}};
		else if (port == 2'd1)
			return {2{h}};
		else
			return w;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected)
		begin
			$display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("TB FAILED");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	// ------------------------------------------------------------
	// master side
	// ------------------------------------------------------------

	task automatic drive_req(input port_idx_t port, input logic [31:0] addr,
			input logic [31:0] wdata, input logic wr);
		p_addr[port]  = addr;
		p_wdata[port] = wdata;
		p_be[port]    = 4'hf;
		p_wr[port]    = wr;
		p_req[port]   = 1'b1;
	endtask

	task automatic wait_ack(input port_idx_t port);
		do
			@(posedge dev_clk);
		while (p_ack[port] !== 1'b1);
	endtask

	task automatic release_req(input port_idx_t port);
		#2;
		p_req[port] = 1'b0;
		@(posedge dev_clk);
		check_value(32'(p_ack[port]), 32'd0, $sformatf("p%0d ack wider than one cycle", port));
		#2;
	endtask

	task automatic access(input port_idx_t port, input logic [31:0] addr,
			input logic [31:0] wdata, input logic wr, output logic [31:0] rdata);
		drive_req(port, addr, wdata, wr);
		wait_ack(port);
		rdata = p_rdata[port];
		release_req(port);
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------

	task automatic test_reset_state();
		check_value(32'(dev_req), 32'd0, "dev_req after reset");
		check_value(32'(dev_wr), 32'd0, "dev_wr after reset");
		check_value(32'(p_ack), 32'd0, "pn_ack after reset");
		check_value(32'(p0_busack), 32'd0, "p0_busack with p0_busreq low");
		check_value(p_rdata[0], 32'd0, "p0_rdata after reset");
		check_value(p_rdata[1], 32'd0, "p1_rdata after reset");
		check_value(p_rdata[2], 32'd0, "p2_rdata after reset");
		check_value(p_rdata[3], 32'd0, "p3_rdata after reset");
	endtask

	task automatic test_word_access();
		logic [31:0] data;
		int          base;
		access(2'd3, 32'h40, 32'hc0de_1234, 1'b1, data);
		ref_mem[16] = 32'hc0de_1234;
		access(2'd0, 32'h40, '0, 1'b0, data);
		check_value(data, ref_mem[16], "p0 word read");
		drive_req(2'd3, 32'h44, 32'h1122_3344, 1'b1);
		p_be[3] = 4'h5;	// bytes 2 and 0 only
		wait_ack(2'd3);
		release_req(2'd3);
		ref_mem[17][23:16] = 8'h22;
		ref_mem[17][7:0]   = 8'h44;
		access(2'd0, 32'h44, '0, 1'b0, data);
		check_value(data, ref_mem[17], "p0 read after byte-enable write");
		base = addr_log.size();
		drive_req(2'd3, 32'h40, '0, 1'b0);
		wait_ack(2'd3);
		check_value(p_rdata[3], ref_mem[16], "p3 word read");
		repeat (6)
		begin
			@(posedge dev_clk);	// req kept high
			check_value(32'(dev_req), 32'd0, "dev_req while p3 holds req");
			check_value(32'(p_ack[3]), 32'd0, "p3 ack while req held");
		end
		check_value(32'(addr_log.size() - base), 32'd1, "device requests for one p3 read");
		release_req(2'd3);
	endtask

	task automatic test_narrow_reads();
		logic [31:0] addr;
		logic [31:0] data;
		logic [5:0]  w;
		logic [2:0]  k;
		for (w = 6'd8; w < 6'd12; w++)
		begin
			for (k = 3'd0; k < 3'd4; k++)
			begin
				addr = {24'd0, w, k[1:0]};
				access(2'd2, addr, '0, 1'b0, data);
				check_value(data, expect_read(2'd2, addr), $sformatf("p2 byte at %h", addr));
				if (!k[0])
				begin
					access(2'd1, addr, '0, 1'b0, data);
					check_value(data, expect_read(2'd1, addr), $sformatf("p1 half at %h", addr));
				end
			end
		end
	endtask

	task automatic test_priority();
		logic [2:0] served;
		int         base;
		base = addr_log.size();
		drive_req(2'd1, 32'h24, '0, 1'b0);	// all three in one cycle
		drive_req(2'd2, 32'h31, '0, 1'b0);
		drive_req(2'd3, 32'h38, '0, 1'b0);
		served = 3'b000;
		while (served != 3'b111)
		begin
			@(posedge dev_clk);
			if (p_ack[1])
			begin
				check_value(p_rdata[1], expect_read(2'd1, 32'h24), "p1 read under contention");
				served[0] = 1'b1;
			end
			if (p_ack[2])
			begin
				check_value(p_rdata[2], expect_read(2'd2, 32'h31), "p2 read under contention");
				served[1] = 1'b1;
			end
			if (p_ack[3])
			begin
				check_value(p_rdata[3], expect_read(2'd3, 32'h38), "p3 read under contention");
				served[2] = 1'b1;
			end
			#2;
			p_req[3:1] = p_req[3:1] & ~served;
		end
		@(posedge dev_clk);
		#2;
		check_value(32'(addr_log.size() - base), 32'd3, "device requests in priority test");
		check_value(addr_log[base], 32'h24, "first grant to p1");
		check_value(addr_log[base + 1], 32'h31, "second grant to p2");
		check_value(addr_log[base + 2], 32'h38, "third grant to p3");
	endtask

	task automatic test_lock();
		logic [31:0] data;
		int          base;
		p0_busreq = 1'b1;
		@(posedge dev_clk);
		check_value(32'(p0_busack), 32'd1, "p0_busack follows p0_busreq");
		#2;
		base = addr_log.size();
		drive_req(2'd2, 32'h4b, '0, 1'b0);
		repeat (20)
		begin
			@(posedge dev_clk);
			check_value(32'(dev_req), 32'd0, "dev_req for p2 during lock");
		end
		#2;
		access(2'd0, 32'h50, '0, 1'b0, data);
		check_value(data, expect_read(2'd0, 32'h50), "p0 read under lock");
		check_value(32'(addr_log.size() - base), 32'd1, "device requests under lock");
		p0_busreq = 1'b0;
		wait_ack(2'd2);
		check_value(p_rdata[2], expect_read(2'd2, 32'h4b), "p2 read after lock drop");
		release_req(2'd2);
	endtask

	initial
	begin
		logic [6:0] i;
		dev_rst_n = 1'b0;
		p0_busreq = 1'b0;
		p_addr    = '0;
		p_wdata   = '0;
		p_be      = '0;
		p_wr      = '0;
		p_req     = '0;
		for (i = 7'd0; i < 7'd64; i++)
			ref_mem[i[5:0]] = fill_word(i[5:0]);
		repeat (2)
			@(posedge dev_clk);
		#2;
		dev_rst_n = 1'b1;
		test_reset_state();
		test_word_access();
		test_narrow_reads();
		test_priority();
		test_lock();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== gen_arb32.f ====
arb_pkg.sv
arb_port_if.sv
arb_port_ctrl.sv
arb_dev_seq.sv
gen_arb32.sv
gen_arb32_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f gen_arb32.f \
	--top-module gen_arb32_tb -o gen_arb32_sim
./obj_dir/gen_arb32_sim
